// File: bench/u2_ctrl_testdata.txt
# cmd     addr  data      expect    name   (all numbers hex)
# data: write value, read mask, input levels, check mask, wait cycles or poll {min,max}
# inputs bits: 0 serdes_link_up, 1 clk_status, 2 phy_int_n, 3 sim_mode, 7..4 clock_divider
# check bits: 7..0 leds, 8 phy_resetn, 9 proc_int, 13..10 adc, 17..14 ser, 21..18 clk, 22 ready
check     0000  007fffff  00000100  reset_outputs
write     0000  0000001b  00000000  sr_clk_write
check     0000  007c0000  006c0000  sr_clk_outputs
write     0004  00000009  00000000  sr_ser_write
check     0000  0003c000  00024000  sr_ser_outputs
write     0008  00000006  00000000  sr_adc_write
check     0000  00003c00  00001800  sr_adc_outputs
write     0010  00000001  00000000  sr_phy_assert
check     0000  00000100  00000000  phy_in_reset
write     0010  00000000  00000000  sr_phy_release
check     0000  00000100  00000100  phy_out_of_reset
write     000c  000000a5  00000000  sr_led_write
write     0020  00000003  00000000  sr_led_src_write
check     0000  000000ff  000000a4  leds_hw_low
inputs    0000  00000005  00000000  serdes_link_up
check     0000  000000ff  000000a5  leds_serdes_up
inputs    0000  00000007  00000000  both_status_up
check     0000  000000ff  000000a7  leds_both_up
inputs    0000  00000006  00000000  clk_status_only
check     0000  000000ff  000000a6  leds_clk_only
write     0400  00000002  00000000  mask_onetime
write     0318  0000000a  00000000  onetime_arm
poll      0000  000a000e  00000001  onetime_irq_rises
read      0404  00000002  00000002  pending_onetime
write     0404  00000002  00000000  clear_onetime
check     0000  00000200  00000000  onetime_irq_cleared
write     031c  00000010  00000000  periodic_start
wait      0000  00000014  00000000  periodic_run
read      0404  00001000  00001000  pending_periodic
write     031c  00000000  00000000  periodic_stop
write     0404  00001000  00000000  clear_periodic
read      0404  00001000  00000000  periodic_cleared
write     031c  00000010  00000000  periodic_restart
wait      0000  00000014  00000000  periodic_rerun
read      0404  00001000  00001000  pending_periodic_again
inputs    0000  00000003  00000000  phy_int_assert
wait      0000  00000002  00000000  phy_edge_settle
read      0404  00000010  00000010  pending_phy
check     0000  00000200  00000000  phy_irq_masked
write     0400  00000012  00000000  mask_phy
check     0000  00000200  00000200  phy_irq_enabled
read      0400  0000ffff  00000012  mask_readback
inputs    0000  0000005b  00000000  board_cfg_a
read      0824  ffffffff  80000005  board_cfg_a_read
read      0834  ffffefff  00000c10  irq_levels_a
inputs    0000  00000024  00000000  board_cfg_b
read      0824  ffffffff  00000002  board_cfg_b_read
read      0834  ffffefff  00000000  irq_levels_b
read      083c  00000000  00000000  cycles_first
delta     083c  00000000  00000002  cycles_back_to_back
# The wait starts in the ack cycle, so 5 waits leave 4 idle cycles
wait      0000  00000005  00000000  cycles_idle
delta     083c  00000000  00000006  cycles_after_idle

// File: u2_ctrl_top.f
+incdir+hdl
hdl/u2_ctrl_pkg.sv
hdl/settings_bus.sv
hdl/ctrl_setting_regs.sv
hdl/simple_timer.sv
hdl/pic.sv
hdl/readback_mux.sv
hdl/u2_ctrl_top.sv
bench/tb_clkgen.sv
bench/tb_u2_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the control core testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f u2_ctrl_top.f --top-module tb_u2_ctrl \
   -Mdir obj_dir -o sim_u2_ctrl && \
   ./obj_dir/sim_u2_ctrl | tee /dev/stderr | grep "Simulation PASSED" > /dev/null && \
   echo "Run result: pass" || \
   { echo "Run result: fail"; exit 1; }

// File: bench/tb_u2_ctrl.sv
/* Testbench for the control core. Commands are read from bench/u2_ctrl_testdata.txt,
   so the run must start in the project root. Inputs change on falling edges. */

`timescale 1ns/1ps

module tb_u2_ctrl;
   import u2_ctrl_pkg::*;

   localparam int CLK_PERIOD_NS = 8;
   localparam int ACK_TIMEOUT   = 16;
   localparam int CMD_CYCLES    = 20;
   localparam int RESET_CYCLES  = 2;

   logic        dsp_clk;
   logic        wb_rst;
   logic        wb_stb_i;
   logic        wb_we_i;
   wb_adr_t     wb_adr_i;
   wb_dat_t     wb_dat_i;
   wb_dat_t     wb_dat_o;
   logic        wb_ack_o;
   logic        clk_status_i, serdes_link_up_i, phy_int_n_i, sim_mode_i;
   logic [3:0]  clock_divider_i;
   logic        clock_ready_o;
   logic [1:0]  clk_en_o, clk_sel_o;
   logic        ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic        adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;
   logic        phy_resetn_o, proc_int_o;
   logic [7:0]  leds_o;
   logic [31:0] out_word;

   // Command table loaded from the data file
   string       cmd_q[$];
   logic [31:0] addr_q[$];
   logic [31:0] data_q[$];
   logic [31:0] exp_q[$];
   string       name_q[$];

   bit          loaded;
   int          limit_cycles;
   int          checks_run;
   int          check_errors;
   int          other_errors;
   logic [31:0] last_read;

   tb_clkgen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clkgen (.clk_o(dsp_clk));

   u2_ctrl_top dut (
      .dsp_clk, .wb_rst, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
      .clk_status_i, .serdes_link_up_i, .phy_int_n_i, .sim_mode_i, .clock_divider_i,
      .clock_ready_o, .clk_en_o, .clk_sel_o,
      .ser_enable_o, .ser_prbsen_o, .ser_loopen_o, .ser_rx_en_o,
      .adc_oe_a_o, .adc_on_a_o, .adc_oe_b_o, .adc_on_b_o,
      .phy_resetn_o, .leds_o, .proc_int_o
   );

   // Check command output word with the bit layout of the data file header
   assign out_word = {9'd0, clock_ready_o, clk_en_o, clk_sel_o,
                      ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o,
                      adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o,
                      proc_int_o, phy_resetn_o, leds_o};

   ////////////////////////////////////////
   // File loading
   ////////////////////////////////////////
   task automatic load_commands(input int fd);
      string       line;
      string       cmd;
      string       name;
      logic [31:0] a, d, e;
      int          cnt;
      while (!$feof(fd)) begin
         cnt = $fgets(line, fd);
         if (cnt > 0 && line.len() > 0 && line[0] != "#") begin
            if ($sscanf(line, "%s %h %h %h %s", cmd, a, d, e, name) == 5) begin
               cmd_q.push_back(cmd);
               addr_q.push_back(a);
               data_q.push_back(d);
               exp_q.push_back(e);
               name_q.push_back(name);
            end
         end
      end
   endtask

   // Waits and poll ranges plus a fixed allowance per command
   function automatic int run_limit();
      int total;
      total = RESET_CYCLES + 2 + CMD_CYCLES * cmd_q.size();
      foreach (cmd_q[i]) begin
         if (cmd_q[i] == "wait")
            total += int'(data_q[i]);
         else if (cmd_q[i] == "poll")
            total += int'(data_q[i][15:0]);
      end
      return total;
   endfunction

   ////////////////////////////////////////
   // Stimulus and checks
   ////////////////////////////////////////
   task automatic drive_inputs(input logic [31:0] val);
      serdes_link_up_i = val[0];
      clk_status_i     = val[1];
      phy_int_n_i      = val[2];
      sim_mode_i       = val[3];
      clock_divider_i  = val[7:4];
   endtask

   // Starts on a falling edge and returns on the falling edge inside the ack cycle
   task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                             input string name, output logic [31:0] rdata);
      int   waited;
      logic got_ack;
      waited   = 0;
      got_ack  = 1'b0;
      rdata    = '0;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = addr[15:0];
      wb_dat_i = wdata;
      while (!got_ack && waited < ACK_TIMEOUT) begin
         @(negedge dsp_clk);
         waited++;
         if (wb_ack_o) begin
            got_ack = 1'b1;
            rdata   = wb_dat_o;
         end
      end
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      if (!got_ack) begin
         $display("ERROR %s: the DUT never acknowledged address %h", name, addr[15:0]);
         other_errors++;
      end
   endtask

   task automatic compare_word(input string name, input logic [31:0] expv,
                               input logic [31:0] act);
      checks_run++;
      assert (act == expv) else begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expv, act);
         check_errors++;
      end
   endtask

   // Range is {min, max} in cycles
   task automatic poll_interrupt(input logic [31:0] range, input logic [31:0] expv,
                                 input string name);
      int lo, hi, n;
      lo = int'(range[31:16]);
      hi = int'(range[15:0]);
      n  = 0;
      while (proc_int_o != expv[0] && n < hi) begin
         @(negedge dsp_clk);
         n++;
      end
      checks_run++;
      assert (proc_int_o == expv[0]) else begin
         $display("ERROR %s: proc_int_o did not reach %0d within %0d cycles",
                  name, expv[0], hi);
         check_errors++;
      end
      assert (n >= lo) else begin
         $display("CHECK FAILED %s: expected %0d to %0d cycles, actual %0d", name, lo, hi, n);
         check_errors++;
      end
   endtask

   task automatic run_command(input int idx);
      string       cmd;
      string       name;
      logic [31:0] addr, data, expv, rdata;
      cmd  = cmd_q[idx];
      name = name_q[idx];
      addr = addr_q[idx];
      data = data_q[idx];
      expv = exp_q[idx];
      if (cmd == "write") begin
         bus_access(1'b1, addr, data, name, rdata);
      end else if (cmd == "read") begin
         bus_access(1'b0, addr, 32'd0, name, rdata);
         // A zero mask only records the word for a later delta
         if (data != '0)
            compare_word(name, expv, rdata & data);
         last_read = rdata;
      end else if (cmd == "delta") begin
         bus_access(1'b0, addr, 32'd0, name, rdata);
         compare_word(name, expv, rdata - last_read);
         last_read = rdata;
      end else if (cmd == "inputs") begin
         drive_inputs(data);
      end else if (cmd == "check") begin
         @(negedge dsp_clk);
         compare_word(name, expv, out_word & data);
      end else if (cmd == "poll") begin
         poll_interrupt(data, expv, name);
      end else if (cmd == "wait") begin
         repeat (data) @(negedge dsp_clk);
      end else begin
         $display("ERROR %s: unknown command %s in the data file", name, cmd);
         other_errors++;
      end
   endtask

   task automatic print_summary();
      $display("Checks run: %0d, check errors: %0d, other errors: %0d",
               checks_run, check_errors, other_errors);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin : main_seq
      int fd;
      wb_rst    = 1'b1;
      wb_stb_i  = 1'b0;
      wb_we_i   = 1'b0;
      wb_adr_i  = '0;
      wb_dat_i  = '0;
      last_read = '0;
      drive_inputs(32'h0000_0004);
      fd = $fopen("bench/u2_ctrl_testdata.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open bench/u2_ctrl_testdata.txt");
         other_errors++;
      end else begin
         load_commands(fd);
         $fclose(fd);
      end
      limit_cycles = run_limit();
      loaded       = 1'b1;
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      @(negedge dsp_clk);
      wb_rst = 1'b0;
      foreach (cmd_q[i])
         run_command(i);
      print_summary();
      if (check_errors == 0 && other_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Stops a stuck run
   initial begin : watchdog
      wait (loaded);
      repeat (limit_cycles) @(posedge dsp_clk);
      $display("ERROR: watchdog expired after %0d cycles, the run did not finish", limit_cycles);
      other_errors++;
      print_summary();
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: bench/tb_clkgen.sv
/* Free-running testbench clock, starts low. */

`timescale 1ns/1ps

module tb_clkgen #(
   parameter int PERIOD_NS = 8
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

endmodule

// File: hdl/u2_ctrl_top.sv
/* Control core top level. Accesses to address bits 11..10 = 3 are never
   acknowledged, so the master must not issue them. */

`timescale 1ns/1ps
`include "u2_ctrl_macros.svh"

module u2_ctrl_top (
   input  logic                 dsp_clk,
   input  logic                 wb_rst,
   input  logic                 wb_stb_i,
   input  logic                 wb_we_i,
   input  u2_ctrl_pkg::wb_adr_t wb_adr_i,
   input  u2_ctrl_pkg::wb_dat_t wb_dat_i,
   output u2_ctrl_pkg::wb_dat_t wb_dat_o,
   output logic                 wb_ack_o,
   input  logic                 clk_status_i,
   input  logic                 serdes_link_up_i,
   input  logic                 phy_int_n_i,
   input  logic                 sim_mode_i,
   input  logic [3:0]           clock_divider_i,
   output logic                 clock_ready_o,
   output logic [1:0]           clk_en_o,
   output logic [1:0]           clk_sel_o,
   output logic                 ser_enable_o,
   output logic                 ser_prbsen_o,
   output logic                 ser_loopen_o,
   output logic                 ser_rx_en_o,
   output logic                 adc_oe_a_o,
   output logic                 adc_on_a_o,
   output logic                 adc_oe_b_o,
   output logic                 adc_on_b_o,
   output logic                 phy_resetn_o,
   output logic [7:0]           leds_o,
   output logic                 proc_int_o
);
   import u2_ctrl_pkg::*;

   wb_slave_e slv_sel;
   logic      set_bus_stb, pic_stb, rb_stb;
   logic      set_bus_ack, pic_ack, rb_ack;
   wb_dat_t   pic_dat, rb_dat;
   set_addr_t set_addr;
   set_data_t set_data;
   logic      set_stb;
   logic      onetime_int, periodic_int;
   irq_vec_t  irq;

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////
   assign slv_sel = wb_slave_e'(wb_adr_i[`WB_SLV_MSB:`WB_SLV_LSB]);

   always_comb begin
      set_bus_stb = 1'b0;
      pic_stb     = 1'b0;
      rb_stb      = 1'b0;
      case (slv_sel)
         SLV_SETTINGS: set_bus_stb = wb_stb_i;
         SLV_PIC:      pic_stb     = wb_stb_i;
         SLV_READBACK: rb_stb      = wb_stb_i;
         default: begin
            // SLV_NONE, no slave answers
         end
      endcase
   end

   // Idle slaves drive zero, so a plain OR is enough
   assign wb_ack_o = set_bus_ack | pic_ack | rb_ack;
   assign wb_dat_o = pic_dat | rb_dat;

   // Interrupt sources, PHY line is active low
   always_comb begin
      irq                   = '0;
      irq[`IRQ_ONETIME]     = onetime_int;
      irq[`IRQ_PHY]         = ~phy_int_n_i;
      irq[`IRQ_SERDES_LINK] = serdes_link_up_i;
      irq[`IRQ_CLK_STATUS]  = clk_status_i;
      irq[`IRQ_PERIODIC]    = periodic_int;
   end

   ////////////////////////////////////////
   // Slaves
   ////////////////////////////////////////
   settings_bus u_settings_bus (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .stb_i(set_bus_stb), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .ack_o(set_bus_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data)
   );

   ctrl_setting_regs u_ctrl_setting_regs (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o)
   );

   simple_timer u_simple_timer (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .onetime_int_o(onetime_int), .periodic_int_o(periodic_int)
   );

   pic u_pic (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .stb_i(pic_stb), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .dat_o(pic_dat), .ack_o(pic_ack), .irq_i(irq), .int_o(proc_int_o)
   );

   readback_mux u_readback_mux (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .stb_i(rb_stb), .adr_i(wb_adr_i), .dat_o(rb_dat), .ack_o(rb_ack),
      .irq_i(irq), .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i)
   );

endmodule

// File: hdl/readback_mux.sv
/* Read-only status words. Writes are acknowledged and dropped.
   The cycle counter wraps at 2^32. */

`timescale 1ns/1ps
`include "u2_ctrl_macros.svh"

module readback_mux (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  logic                  stb_i,
   input  u2_ctrl_pkg::wb_adr_t  adr_i,
   output u2_ctrl_pkg::wb_dat_t  dat_o,
   output logic                  ack_o,
   input  u2_ctrl_pkg::irq_vec_t irq_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i
);
   import u2_ctrl_pkg::*;

   wb_dat_t cycle_cnt;
   wb_dat_t word;

   // Free-running cycle counter
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_cnt <= '0;
         ack_o     <= 1'b0;
      end else begin
         cycle_cnt <= cycle_cnt + 1'b1;
         ack_o     <= stb_i & ~ack_o;
      end
   end

   always_comb begin
      case (adr_i[`RB_WORD_MSB:`WORD_LSB])
         `RB_BOARD_CFG: word = {sim_mode_i, 27'd0, clock_divider_i};
         `RB_IRQ:       word = {16'd0, irq_i};
         `RB_CYCLES:    word = cycle_cnt;
         default:       word = '0;
      endcase
   end

   // Sampled on the first edge that sees stb
   always_ff @(posedge dsp_clk) begin
      dat_o <= (stb_i & ~ack_o) ? word : '0;
   end

endmodule

// File: hdl/pic.sv
/* Interrupt controller. Sources are latched on rising edges only, so a
   level held high sets its pending bit once. */

`timescale 1ns/1ps
`include "u2_ctrl_macros.svh"

module pic (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  u2_ctrl_pkg::wb_adr_t  adr_i,
   input  u2_ctrl_pkg::wb_dat_t  dat_i,
   output u2_ctrl_pkg::wb_dat_t  dat_o,
   output logic                  ack_o,
   input  u2_ctrl_pkg::irq_vec_t irq_i,
   output logic                  int_o
);
   import u2_ctrl_pkg::*;

   irq_vec_t   irq_d, pending, mask;
   irq_vec_t   rise, clr;
   logic [1:0] word;
   logic       access;

   assign word   = adr_i[`PIC_WORD_MSB:`WORD_LSB];
   assign access = stb_i & ~ack_o;
   assign rise   = irq_i & ~irq_d;
   assign clr    = (access && we_i && word == `PIC_PENDING) ? dat_i[15:0] : '0;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_o   <= 1'b0;
         irq_d   <= '0;
         pending <= '0;
         mask    <= '0;
         int_o   <= 1'b0;
      end else begin
         ack_o   <= access;
         irq_d   <= irq_i;
         // New edges win over a clear in the same cycle
         pending <= (pending & ~clr) | rise;
         if (access && we_i && word == `PIC_MASK)
            mask <= dat_i[15:0];
         int_o   <= |(pending & mask);
      end
   end

   // Read data only in the ack cycle
   always_ff @(posedge dsp_clk) begin
      if (access && !we_i && word == `PIC_MASK)
         dat_o <= {16'd0, mask};
      else if (access && !we_i && word == `PIC_PENDING)
         dat_o <= {16'd0, pending};
      else
         dat_o <= '0;
   end

endmodule

// File: hdl/simple_timer.sv
/* One-time and periodic interrupt pulses, counted in dsp_clk cycles.
   Writing 0 to either register stops that timer. */

`timescale 1ns/1ps
`include "u2_ctrl_macros.svh"

module simple_timer (
   input  logic                   dsp_clk,
   input  logic                   wb_rst,
   input  logic                   set_stb_i,
   input  u2_ctrl_pkg::set_addr_t set_addr_i,
   input  u2_ctrl_pkg::set_data_t set_data_i,
   output logic                   onetime_int_o,
   output logic                   periodic_int_o
);
   import u2_ctrl_pkg::*;

   set_data_t onetime_cnt;
   set_data_t period;
   set_data_t period_cnt;

   ////////////////////////////////////////
   // One-time delay, counts down to 1 and stops
   ////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (wb_rst)
         onetime_cnt <= '0;
      else if (set_stb_i && set_addr_i == `SR_SIMTIMER)
         onetime_cnt <= set_data_i;
      else if (onetime_cnt != '0)
         onetime_cnt <= onetime_cnt - 1'b1;
   end

   assign onetime_int_o = (onetime_cnt == 32'd1);

   ////////////////////////////////////////
   // Periodic, reloads the period on the pulse
   ////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         period     <= '0;
         period_cnt <= '0;
      end else if (set_stb_i && set_addr_i == `SR_SIMTIMER + 8'd1) begin
         period     <= set_data_i;
         period_cnt <= set_data_i;
      end else if (period_cnt == 32'd1) begin
         period_cnt <= period;
      end else if (period_cnt != '0) begin
         period_cnt <= period_cnt - 1'b1;
      end
   end

   assign periodic_int_o = (period_cnt == 32'd1);

endmodule

// File: hdl/ctrl_setting_regs.sv
/* Board control registers on the settings bus. LED bits set in SR_LED_SRC
   follow hardware status; only bits 1..0 carry a hardware value. */

`timescale 1ns/1ps
`include "u2_ctrl_macros.svh"

module ctrl_setting_regs (
   input  logic                   dsp_clk,
   input  logic                   wb_rst,
   input  logic                   set_stb_i,
   input  u2_ctrl_pkg::set_addr_t set_addr_i,
   input  u2_ctrl_pkg::set_data_t set_data_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   output logic                   clock_ready_o,
   output logic [1:0]             clk_en_o,
   output logic [1:0]             clk_sel_o,
   output logic                   ser_enable_o,
   output logic                   ser_prbsen_o,
   output logic                   ser_loopen_o,
   output logic                   ser_rx_en_o,
   output logic                   adc_oe_a_o,
   output logic                   adc_on_a_o,
   output logic                   adc_oe_b_o,
   output logic                   adc_on_b_o,
   output logic                   phy_resetn_o,
   output logic [7:0]             leds_o
);

   logic [4:0] clk_reg;
   logic [3:0] ser_reg;
   logic [3:0] adc_reg;
   logic       phy_reset;
   logic [7:0] led_sw, led_src;
   logic [7:0] led_hw;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clk_reg   <= '0;
         ser_reg   <= '0;
         adc_reg   <= '0;
         phy_reset <= 1'b0;
         led_sw    <= '0;
         led_src   <= '0;
      end else if (set_stb_i) begin
         case (set_addr_i)
            `SR_CLK:     clk_reg   <= set_data_i[4:0];
            `SR_SER:     ser_reg   <= set_data_i[3:0];
            `SR_ADC:     adc_reg   <= set_data_i[3:0];
            `SR_PHY:     phy_reset <= set_data_i[0];
            `SR_LED:     led_sw    <= set_data_i[7:0];
            `SR_LED_SRC: led_src   <= set_data_i[7:0];
            default: begin
               // Other addresses belong to other blocks
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Output mapping
   ////////////////////////////////////////
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clk_reg;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = ser_reg;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_reg;
   assign phy_resetn_o = ~phy_reset;

   // Per bit: 1 picks hardware, 0 picks software
   assign led_hw = {6'd0, clk_status_i, serdes_link_up_i};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: hdl/settings_bus.sv
/* Bus writes become one-cycle settings strobes. Reads are acknowledged
   with no data. The master must hold stb until it sees ack. */

`timescale 1ns/1ps
`include "u2_ctrl_macros.svh"

module settings_bus (
   input  logic                   dsp_clk,
   input  logic                   wb_rst,
   input  logic                   stb_i,
   input  logic                   we_i,
   input  u2_ctrl_pkg::wb_adr_t   adr_i,
   input  u2_ctrl_pkg::wb_dat_t   dat_i,
   output logic                   ack_o,
   output logic                   set_stb_o,
   output u2_ctrl_pkg::set_addr_t set_addr_o,
   output u2_ctrl_pkg::set_data_t set_data_o
);

   // Ack for one cycle, strobe alongside it on writes
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_o     <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         ack_o     <= stb_i & ~ack_o;
         set_stb_o <= stb_i & we_i & ~ack_o;
      end
   end

   // Word address, byte lanes dropped
   always_ff @(posedge dsp_clk) begin
      if (stb_i & ~ack_o) begin
         set_addr_o <= adr_i[`SET_ADR_MSB:`WORD_LSB];
         set_data_o <= dat_i;
      end
   end

endmodule

// File: hdl/u2_ctrl_pkg.sv
/* Shared bus, settings and interrupt types for the control core.
   Slave select uses bus address bits 11..10; settings address is bits 9..2. */

package u2_ctrl_pkg;

   ////////////////////////////////////////
   // Bus types
   ////////////////////////////////////////

   // Byte address and data word of the slave port
   typedef logic [15:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;

   ////////////////////////////////////////
   // Settings bus and interrupts
   ////////////////////////////////////////

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // One bit per interrupt source
   typedef logic [15:0] irq_vec_t;

   // Slave chosen by the address decode
   typedef enum logic [1:0] {
      SLV_SETTINGS = 2'd0,
      SLV_PIC      = 2'd1,
      SLV_READBACK = 2'd2,
      SLV_NONE     = 2'd3
   } wb_slave_e;

endpackage

// File: hdl/u2_ctrl_macros.svh
/* Address map, setting-register addresses and interrupt bit positions.
   Word indices count 32-bit words from the slave base address. */

`ifndef U2_CTRL_MACROS_SVH
`define U2_CTRL_MACROS_SVH

// Slave base addresses on the bus
`define BASE_SETTINGS 16'h0000
`define BASE_PIC      16'h0400
`define BASE_READBACK 16'h0800

// Address fields
`define WB_SLV_MSB    11
`define WB_SLV_LSB    10
`define SET_ADR_MSB   9
`define WORD_LSB      2
`define PIC_WORD_MSB  3
`define RB_WORD_MSB   5

////////////////////////////////////////
// Setting-register addresses
////////////////////////////////////////
`define SR_CLK        8'd0
`define SR_SER        8'd1
`define SR_ADC        8'd2
`define SR_LED        8'd3
`define SR_PHY        8'd4
`define SR_LED_SRC    8'd8
// One-time count here, period at the next address
`define SR_SIMTIMER   8'd198

////////////////////////////////////////
// Interrupt bit positions
////////////////////////////////////////
`define IRQ_ONETIME     1
`define IRQ_PHY         4
`define IRQ_SERDES_LINK 10
`define IRQ_CLK_STATUS  11
`define IRQ_PERIODIC    12

// Readback and PIC word indices
`define RB_BOARD_CFG  4'd9
`define RB_IRQ        4'd13
`define RB_CYCLES     4'd15
`define PIC_MASK      2'd0
`define PIC_PENDING   2'd1

`endif
